// ==== include/tile_cfg.svh ====
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// data path
`define DATA_W 32         // one memory word
`define ADDR_W 32         // byte address into src or dst memory

// length counters
`define LEN_W 12          // total words per request, max 4095
`define TILE_WORDS 128    // words per full tile
`define TILE_LEN_W 8      // holds 0..128
`define BUF_AW 7          // tile buffer index

`endif

// ==== source/tile_pkg.sv ====
`default_nettype none

package tile_pkg;

`include "tile_cfg.svh"

    typedef logic [`DATA_W-1:0]     word_t;       // one data word
    typedef logic [`ADDR_W-1:0]     byte_addr_t;  // byte address, word aligned in use
    typedef logic [`LEN_W-1:0]      total_len_t;  // remaining or total word count
    typedef logic [`TILE_LEN_W-1:0] tile_len_t;   // words in one tile
    typedef logic [`BUF_AW-1:0]     buf_addr_t;   // tile buffer index

    // tile sequencer states
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'b00,   // waiting for load_start
        CTRL_LOAD  = 2'b01,   // src -> tile buffer
        CTRL_STORE = 2'b10,   // tile buffer -> dst
        CTRL_DONE  = 2'b11    // one cycle, drives load_done
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/rmst_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tile_cfg.svh"

module rmst_ctrl import tile_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             load_start,         // request pulse
    input  wire byte_addr_t src_base,           // sampled with load_start
    input  wire byte_addr_t dst_base,
    input  wire total_len_t total_len,          // in words
    input  wire             load_trans_done,    // tile is in the buffer
    input  wire             store_trans_done,   // tile is in dst memory
    output logic            busy,
    output logic            load_done,          // one cycle at the end
    output logic            load_trans_start,
    output logic            store_trans_start,
    output byte_addr_t      param_raddr,        // current tile src address
    output byte_addr_t      param_waddr,        // current tile dst address
    output tile_len_t       param_iolen         // current tile length
);

    ctrl_state_t state;
    total_len_t  len;          // words left, including the current tile
    total_len_t  len_left;     // words left after the current tile
    byte_addr_t  tile_bytes;   // byte stride of the current tile

    // clip a word count to one tile
    function automatic tile_len_t tile_cut(input total_len_t n);
        if (n > total_len_t'(`TILE_WORDS)) begin
            return tile_len_t'(`TILE_WORDS);
        end
        return tile_len_t'(n);
    endfunction

    assign len_left   = len - total_len_t'(param_iolen);
    assign tile_bytes = byte_addr_t'(param_iolen) << 2;   // four bytes per word

    assign busy      = (state != CTRL_IDLE);   // rises the edge after load_start
    assign load_done = (state == CTRL_DONE);   // DONE lasts one cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state             <= CTRL_IDLE;
            len               <= '0;
            param_iolen       <= '0;
            load_trans_start  <= 1'b0;
            store_trans_start <= 1'b0;
        end else begin
            load_trans_start  <= 1'b0;   // pulses by default
            store_trans_start <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    if (load_start) begin
                        len         <= total_len;
                        param_iolen <= tile_cut(total_len);   // first tile
                        if (total_len == '0) begin
                            state <= CTRL_DONE;   // nothing to move
                        end else begin
                            state            <= CTRL_LOAD;
                            load_trans_start <= 1'b1;
                        end
                    end
                end
                CTRL_LOAD: begin
                    if (load_trans_done) begin
                        state             <= CTRL_STORE;
                        store_trans_start <= 1'b1;   // buffer full, write it out
                    end
                end
                CTRL_STORE: begin
                    if (store_trans_done) begin
                        len <= len_left;
                        if (len_left == '0) begin
                            state <= CTRL_DONE;
                        end else begin
                            param_iolen      <= tile_cut(len_left);   // next tile
                            load_trans_start <= 1'b1;
                            state            <= CTRL_LOAD;
                        end
                    end
                end
                CTRL_DONE: begin
                    state <= CTRL_IDLE;
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // address bookkeeping
    always_ff @(posedge clk) begin
        if (state == CTRL_IDLE && load_start) begin
            param_raddr <= src_base;
            param_waddr <= dst_base;
        end else if (state == CTRL_STORE && store_trans_done) begin
            param_raddr <= param_raddr + tile_bytes;   // step past stored tile
            param_waddr <= param_waddr + tile_bytes;
        end
    end

endmodule

`default_nettype wire

// ==== source/load_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_engine import tile_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             load_trans_start,   // from rmst_ctrl
    input  wire byte_addr_t param_raddr,
    input  wire tile_len_t  param_iolen,        // held stable during the tile
    input  wire word_t      rd_data,            // valid the cycle after rd_en
    output logic            rd_en,
    output byte_addr_t      rd_addr,
    output logic            buf_we,
    output buf_addr_t       buf_waddr,
    output word_t           buf_wdata,
    output logic            load_trans_done
);

    tile_len_t cnt;        // reads issued so far
    logic      rd_last;    // final read of the tile this cycle
    logic      rd_vld;     // rd_data valid
    logic      vld_last;   // last word arriving
    buf_addr_t rd_idx;     // buffer slot of the arriving word

    assign rd_last = rd_en && (cnt == param_iolen - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_en           <= 1'b0;
            cnt             <= '0;
            rd_vld          <= 1'b0;
            vld_last        <= 1'b0;
            load_trans_done <= 1'b0;
        end else begin
            rd_vld          <= rd_en;      // one cycle read latency
            vld_last        <= rd_last;
            load_trans_done <= vld_last;   // cycle after last buffer write
            if (load_trans_start) begin
                rd_en <= 1'b1;
                cnt   <= '0;
            end else if (rd_en) begin
                cnt <= cnt + 1'b1;
                if (rd_last) begin
                    rd_en <= 1'b0;   // iolen reads issued
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_trans_start) begin
            rd_addr <= param_raddr;
        end else if (rd_en) begin
            rd_addr <= rd_addr + byte_addr_t'(4);   // next word
        end
        rd_idx <= buf_addr_t'(cnt);   // index tracks the data latency
    end

    assign buf_we    = rd_vld;
    assign buf_waddr = rd_idx;
    assign buf_wdata = rd_data;   // word lands in the buffer this edge

endmodule

`default_nettype wire

// ==== source/tile_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tile_cfg.svh"

module tile_buffer import tile_pkg::*; (
    input  wire            clk,
    input  wire            buf_we,      // from load_engine
    input  wire buf_addr_t buf_waddr,
    input  wire word_t     buf_wdata,
    input  wire buf_addr_t buf_raddr,   // from store_engine
    output word_t          buf_rdata    // one cycle after buf_raddr
);

    word_t mem [0:`TILE_WORDS-1];   // one tile of words

    always_ff @(posedge clk) begin
        if (buf_we) begin
            mem[buf_waddr] <= buf_wdata;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        buf_rdata <= mem[buf_raddr];
    end

endmodule

`default_nettype wire

// ==== source/store_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_engine import tile_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             store_trans_start,   // from rmst_ctrl
    input  wire byte_addr_t param_waddr,
    input  wire tile_len_t  param_iolen,
    input  wire word_t      buf_rdata,           // one cycle after buf_raddr
    output buf_addr_t       buf_raddr,
    output logic            wr_en,
    output byte_addr_t      wr_addr,
    output word_t           wr_data,
    output logic            store_trans_done
);

    tile_len_t cnt;       // buffer reads issued
    logic      rd_act;    // buffer read in flight
    logic      rd_last;   // last buffer read this cycle
    logic      wr_last;   // last dst write this cycle

    assign rd_last   = rd_act && (cnt == param_iolen - 1'b1);
    assign buf_raddr = buf_addr_t'(cnt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_act           <= 1'b0;
            cnt              <= '0;
            wr_en            <= 1'b0;
            wr_last          <= 1'b0;
            store_trans_done <= 1'b0;
        end else begin
            wr_en            <= rd_act;    // line up with buf_rdata
            wr_last          <= rd_last;
            store_trans_done <= wr_last;   // cycle after last write
            if (store_trans_start) begin
                rd_act <= 1'b1;
                cnt    <= '0;
            end else if (rd_act) begin
                cnt <= cnt + 1'b1;
                if (rd_last) begin
                    rd_act <= 1'b0;
                end
            end
        end
    end

    // dst address steps once per write
    always_ff @(posedge clk) begin
        if (store_trans_start) begin
            wr_addr <= param_waddr;
        end else if (wr_en) begin
            wr_addr <= wr_addr + byte_addr_t'(4);
        end
    end

    assign wr_data = buf_rdata;   // plain copy, no datapath

endmodule

`default_nettype wire

// ==== source/tile_copy_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_copy_top import tile_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             load_start,
    input  wire byte_addr_t src_base,
    input  wire byte_addr_t dst_base,
    input  wire total_len_t total_len,
    output logic            busy,
    output logic            load_done,
    output logic            rd_en,       // src memory
    output byte_addr_t      rd_addr,
    input  wire word_t      rd_data,
    output logic            wr_en,       // dst memory
    output byte_addr_t      wr_addr,
    output word_t           wr_data
);

    byte_addr_t param_raddr;
    byte_addr_t param_waddr;
    tile_len_t  param_iolen;
    logic       load_trans_start;
    logic       load_trans_done;
    logic       store_trans_start;
    logic       store_trans_done;
    logic       buf_we;
    buf_addr_t  buf_waddr;
    word_t      buf_wdata;
    buf_addr_t  buf_raddr;
    word_t      buf_rdata;

    rmst_ctrl u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .load_start        (load_start),
        .src_base          (src_base),
        .dst_base          (dst_base),
        .total_len         (total_len),
        .load_trans_done   (load_trans_done),
        .store_trans_done  (store_trans_done),
        .busy              (busy),
        .load_done         (load_done),
        .load_trans_start  (load_trans_start),
        .store_trans_start (store_trans_start),
        .param_raddr       (param_raddr),
        .param_waddr       (param_waddr),
        .param_iolen       (param_iolen)
    );

    load_engine u_load (
        .clk              (clk),
        .rst              (rst),
        .load_trans_start (load_trans_start),
        .param_raddr      (param_raddr),
        .param_iolen      (param_iolen),
        .rd_data          (rd_data),
        .rd_en            (rd_en),
        .rd_addr          (rd_addr),
        .buf_we           (buf_we),
        .buf_waddr        (buf_waddr),
        .buf_wdata        (buf_wdata),
        .load_trans_done  (load_trans_done)
    );

    tile_buffer u_buf (
        .clk       (clk),
        .buf_we    (buf_we),
        .buf_waddr (buf_waddr),
        .buf_wdata (buf_wdata),
        .buf_raddr (buf_raddr),
        .buf_rdata (buf_rdata)
    );

    store_engine u_store (
        .clk               (clk),
        .rst               (rst),
        .store_trans_start (store_trans_start),
        .param_waddr       (param_waddr),
        .param_iolen       (param_iolen),
        .buf_rdata         (buf_rdata),
        .buf_raddr         (buf_raddr),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .store_trans_done  (store_trans_done)
    );

endmodule

`default_nettype wire

// ==== test/tile_copy_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_copy_assert import tile_pkg::*; (
    input wire             clk,
    input wire             rst,
    input wire             busy,
    input wire             load_done,
    input wire             rd_en,
    input wire byte_addr_t rd_addr,
    input wire             wr_en,
    input wire byte_addr_t wr_addr
);

    int fail_cnt = 0;   // failed assertion count, read at end of run

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) load_done |=> !load_done)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("load_done high for more than one cycle");
        end

    a_no_overlap: assert property (@(posedge clk) disable iff (rst) !(rd_en && wr_en))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rd_en and wr_en high together");
        end

    a_idle_after: assert property (@(posedge clk) disable iff (rst) load_done |=> !busy)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("busy still high after load_done");
        end

    // word aligned traffic only
    a_rd_align: assert property (@(posedge clk) disable iff (rst) rd_en |-> rd_addr[1:0] == 2'b00)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rd_addr not word aligned");
        end

    a_wr_align: assert property (@(posedge clk) disable iff (rst) wr_en |-> wr_addr[1:0] == 2'b00)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("wr_addr not word aligned");
        end

    a_rst_quiet: assert property (@(posedge clk) rst |-> !busy && !load_done && !rd_en && !wr_en)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("control output high during reset");
        end

endmodule

`default_nettype wire

// ==== test/tile_copy_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_copy_tb import tile_pkg::*; ();

    localparam int          MEM_WORDS = 4096;           // src and dst depth
    localparam logic [31:0] SEED      = 32'h121fe072;
    localparam int          TO_FACTOR = 4;              // cycles allowed per word
    localparam int          TO_MARGIN = 2000;           // reset, gaps, tile overhead
    localparam int          N_RAND    = 8;              // random requests

    logic       clk = 1'b0;
    logic       rst;
    logic       load_start;
    byte_addr_t src_base;
    byte_addr_t dst_base;
    total_len_t total_len;
    logic       busy;
    logic       load_done;
    logic       rd_en;
    byte_addr_t rd_addr;
    word_t      rd_data = '0;      // src memory read port
    logic       wr_en;
    byte_addr_t wr_addr;
    word_t      wr_data;

    word_t       src_mem [MEM_WORDS];
    word_t       dst_mem [MEM_WORDS];
    logic        dst_hit [MEM_WORDS];   // word was written
    word_t       exp_mem [MEM_WORDS];
    logic        exp_hit [MEM_WORDS];
    logic        rd_pend = 1'b0;        // read issued last cycle
    byte_addr_t  rd_pend_addr = '0;
    logic        clear_mem;
    logic        plan_ready = 1'b0;
    int          rd_cnt = 0;
    int          wr_cnt = 0;
    int          stray_cnt = 0;         // writes outside dst memory
    int          done_cnt = 0;
    int          exp_cnt = 0;
    int          data_errs = 0;
    int          ctrl_errs = 0;
    int          total_words;
    logic [31:0] rng;
    byte_addr_t  r_src [N_RAND];
    byte_addr_t  r_dst [N_RAND];
    total_len_t  r_len [N_RAND];
    event        done_ev;

    tile_copy_top dut0 (.*);

    bind tile_copy_top tile_copy_assert u_chk (
        .clk(clk), .rst(rst), .busy(busy), .load_done(load_done),
        .rd_en(rd_en), .rd_addr(rd_addr), .wr_en(wr_en), .wr_addr(wr_addr)
    );

    always #2 clk = ~clk;   // 4 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word i of the request lands at dst word + i, one write per word
    function automatic int copy_ref(input byte_addr_t src, input byte_addr_t dst,
                                    input total_len_t len);
        int s;
        int d;
        s = int'(src >> 2);
        d = int'(dst >> 2);
        for (int i = 0; i < MEM_WORDS; i++) begin
            exp_hit[i] = 1'b0;
            exp_mem[i] = '0;
        end
        for (int i = 0; i < int'(len); i++) begin
            exp_hit[d + i] = 1'b1;
            exp_mem[d + i] = src_mem[s + i];
        end
        return int'(len);
    endfunction

    // memory models, sampled mid cycle
    always @(negedge clk) begin
        if (clear_mem) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                dst_mem[i] = '0;
                dst_hit[i] = 1'b0;
            end
            rd_cnt    = 0;
            wr_cnt    = 0;
            stray_cnt = 0;
        end
        if (rd_pend) begin
            rd_data = src_mem[rd_pend_addr[13:2]];   // one cycle latency
        end
        rd_pend      = rd_en;
        rd_pend_addr = rd_addr;
        if (rd_en) begin
            rd_cnt++;
        end
        if (wr_en) begin
            wr_cnt++;
            if (wr_addr < byte_addr_t'(MEM_WORDS * 4)) begin
                dst_mem[wr_addr[13:2]] = wr_data;
                dst_hit[wr_addr[13:2]] = 1'b1;
            end else begin
                stray_cnt++;
            end
        end
        if (load_done) begin
            done_cnt++;
            -> done_ev;
        end
    end

    // result check on every load_done
    always @(done_ev) begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (exp_hit[i] && !dst_hit[i]) begin
                $display("no write reached dst byte address %h", byte_addr_t'(i * 4));
                data_errs++;
            end else if (!exp_hit[i] && dst_hit[i]) begin
                $display("unexpected write at dst byte address %h", byte_addr_t'(i * 4));
                data_errs++;
            end else if (exp_hit[i] && dst_mem[i] !== exp_mem[i]) begin
                $display("Error: wr_data at %h expected %h got %h",
                         byte_addr_t'(i * 4), exp_mem[i], dst_mem[i]);
                data_errs++;
            end
        end
        if (wr_cnt != exp_cnt) begin
            $display("Error: wr_en count expected %h got %h", exp_cnt, wr_cnt);
            data_errs++;
        end
        if (rd_cnt != exp_cnt) begin
            $display("Error: rd_en count expected %h got %h", exp_cnt, rd_cnt);
            data_errs++;
        end
        if (stray_cnt != 0) begin
            $display("%0d writes went past the end of dst memory", stray_cnt);
            data_errs++;
        end
    end

    task automatic prepare(input byte_addr_t src, input byte_addr_t dst, input total_len_t len);
        exp_cnt = copy_ref(src, dst, len);
        @(posedge clk);
        clear_mem = 1'b1;   // dst memory and counters back to zero
        @(posedge clk);
        clear_mem = 1'b0;   // held across exactly one falling edge
    endtask

    task automatic pulse_start(input byte_addr_t src, input byte_addr_t dst, input total_len_t len);
        @(negedge clk);
        src_base   = src;
        dst_base   = dst;
        total_len  = len;
        load_start = 1'b1;
        @(negedge clk);
        load_start = 1'b0;
    endtask

    task automatic wait_done(input int base);
        do @(posedge clk); while (done_cnt == base);
        repeat (4) @(negedge clk);   // room for a stray second pulse
        if (done_cnt != base + 1) begin
            $display("Error: load_done pulses expected %h got %h", 1, done_cnt - base);
            ctrl_errs++;
        end
        if (busy) begin
            $display("busy stayed high after the request finished");
            ctrl_errs++;
        end
    endtask

    task automatic run_copy(input byte_addr_t src, input byte_addr_t dst, input total_len_t len);
        int base;
        prepare(src, dst, len);
        base = done_cnt;
        pulse_start(src, dst, len);
        wait_done(base);
    endtask

    initial begin
        int base;
        rst        = 1'b1;
        load_start = 1'b0;
        src_base   = '0;
        dst_base   = '0;
        total_len  = '0;
        clear_mem  = 1'b0;
        rng        = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            rng        = xorshift(rng);
            src_mem[i] = rng;
        end
        total_words = 256 + 300 + 5 + 40;   // directed requests
        for (int k = 0; k < N_RAND; k++) begin
            rng      = xorshift(rng);
            r_len[k] = total_len_t'(rng % 32'd600 + 32'd1);
            rng      = xorshift(rng);
            r_src[k] = byte_addr_t'((rng % (MEM_WORDS - int'(r_len[k]) + 1)) << 2);
            rng      = xorshift(rng);
            r_dst[k] = byte_addr_t'((rng % (MEM_WORDS - int'(r_len[k]) + 1)) << 2);
            total_words += int'(r_len[k]);
        end
        plan_ready = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        run_copy(32'h0000_0100, 32'h0000_2000, 256);   // two full tiles
        run_copy(32'h0000_0040, 32'h0000_0800, 300);   // 128 + 128 + 44
        run_copy(32'h0000_1000, 32'h0000_0010, 5);     // short tile
        run_copy(32'h0000_0200, 32'h0000_0400, 0);     // no traffic

        // second request while busy must be dropped
        prepare(32'h0000_0300, 32'h0000_3000, 40);
        base = done_cnt;
        pulse_start(32'h0000_0300, 32'h0000_3000, 40);
        repeat (10) @(negedge clk);
        if (!busy) begin
            $display("busy was low in the middle of a request");
            ctrl_errs++;
        end
        pulse_start(32'h0000_0500, 32'h0000_3400, 60);
        wait_done(base);

        for (int k = 0; k < N_RAND; k++) begin
            run_copy(r_src[k], r_dst[k], r_len[k]);
        end

        $display("data errors %0d, control errors %0d, assertion failures %0d",
                 data_errs, ctrl_errs, dut0.u_chk.fail_cnt);
        if (data_errs + ctrl_errs + dut0.u_chk.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (plan_ready);
        repeat (TO_FACTOR * total_words + TO_MARGIN) @(posedge clk);
        $display("timeout, the DUT never finished all requests");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
source/tile_pkg.sv
source/rmst_ctrl.sv
source/load_engine.sv
source/tile_buffer.sv
source/store_engine.sv
source/tile_copy_top.sv
test/tile_copy_assert.sv
test/tile_copy_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal -f src.f --top-module tile_copy_tb -Mdir obj_dir \
    && ./obj_dir/Vtile_copy_tb +verilator+error+limit+1000 2>&1 | tee sim.log
grep -q "^Test completed successfully$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
